// File: hdl/mips_cfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// boot vector, first fetch after start
`define MIPS_RESET_VECTOR 32'hBFC0_0000

// a jump here ends the run once its delay slot retires
`define MIPS_HALT_ADDR 32'h0000_0000

// program words mapped at the boot vector
`define MIPS_ROM_WORDS 32'd16

// data RAM depth in words
`define MIPS_RAM_WORDS 1024

// where the program stores A+B
`define MIPS_RESULT_ADDR 32'h0000_0100

`endif

// File: hdl/mips_isa_pkg.sv
package mips_isa_pkg;

    // data and address word
    typedef logic [31:0] word_t;

    typedef logic [4:0] reg_idx_t;

    // I-type immediate, sign extended for arithmetic and addresses
    typedef logic [15:0] imm_t;

    // primary opcodes of the subset
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_regimm  = 6'h01,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addiu   = 6'h09,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_e;

    // function field when opcode is special
    typedef enum logic [5:0] {
        fn_jr   = 6'h08,
        fn_addu = 6'h21,
        fn_subu = 6'h23
    } funct_e;

    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_exec,
        st_mem,
        st_halt_slot
    } cpu_state_e;

    // field extraction
    function automatic reg_idx_t field_rs(word_t instr);
        return instr[25:21];
    endfunction

    function automatic reg_idx_t field_rt(word_t instr);
        return instr[20:16];
    endfunction

    function automatic reg_idx_t field_rd(word_t instr);
        return instr[15:11];
    endfunction

    function automatic word_t sign_extend(imm_t imm);
        return {{16{imm[15]}}, imm};
    endfunction

endpackage

// File: hdl/mips_bus_pkg.sv
package mips_bus_pkg;

    import mips_isa_pkg::*;

    // core data access, held for the mem cycle only
    typedef struct packed {
        word_t addr;
        word_t writedata;
        logic  write;
        logic  read;
    } data_req_t;

    // preload of the data RAM from outside
    // taken only while the core sits idle
    typedef struct packed {
        word_t addr;
        word_t data;
        logic  valid;
    } load_req_t;

    // quiet bus, no access
    localparam data_req_t data_req_none = '{
        addr:      '0,
        writedata: '0,
        write:     1'b0,
        read:      1'b0
    };

endpackage

// File: hdl/mips_instr_rom.sv
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mips_instr_rom
    import mips_isa_pkg::*;
(
    input  word_t instr_address,
    output word_t instr_readdata
);

    localparam int rom_idx_w = $clog2(`MIPS_ROM_WORDS);

    // registers named as the program uses them
    localparam reg_idx_t r_zero = 5'd0;
    localparam reg_idx_t r_v0   = 5'd2;
    localparam reg_idx_t r_v1   = 5'd3;
    localparam reg_idx_t r_a0   = 5'd4;

    word_t                offset;
    logic [rom_idx_w-1:0] rom_idx;
    logic                 in_rom;
    word_t                rom_word;

    // I-type word from its fields
    function automatic word_t enc_i(opcode_e op, reg_idx_t rs, reg_idx_t rt, imm_t imm);
        return {op, rs, rt, imm};
    endfunction

    // R-type word, shamt always zero here
    function automatic word_t enc_r(reg_idx_t rs, reg_idx_t rt, reg_idx_t rd, funct_e fn);
        return {op_special, rs, rt, rd, 5'd0, fn};
    endfunction

    // byte offset into the program window
    assign offset  = instr_address - `MIPS_RESET_VECTOR;
    assign rom_idx = offset[rom_idx_w+1:2];
    assign in_rom  = ((offset >> 2) < `MIPS_ROM_WORDS) && (offset[1:0] == 2'b00);

    always_comb begin
        case (rom_idx)
            // lw v0, 0(zero) is word A
            0: rom_word = enc_i(op_lw, r_zero, r_v0, 16'h0000);
            // lw v1, 4(zero) is word B
            1: rom_word = enc_i(op_lw, r_zero, r_v1, 16'h0004);
            // a0 = A + B
            2: rom_word = enc_r(r_v0, r_v1, r_a0, fn_addu);
            // sum out to the result word
            3: rom_word = enc_i(op_sw, r_zero, r_a0, imm_t'(`MIPS_RESULT_ADDR));
            // beq v0, v1, +2 skips the addiu when A == B
            4: rom_word = enc_i(op_beq, r_v0, r_v1, 16'd2);
            // delay slot, always runs
            5: rom_word = enc_r(r_v0, r_v1, r_v0, fn_subu);
            6: rom_word = enc_i(op_addiu, r_v0, r_v0, 16'd1);
            // jr zero, halts after the slot below
            7: rom_word = enc_r(r_zero, r_zero, r_zero, fn_jr);
            // nop in the halt slot
            8: rom_word = '0;
            default: rom_word = '0;
        endcase
    end

    // anything outside the window reads as nop
    assign instr_readdata = in_rom ? rom_word : '0;

endmodule

// File: hdl/mips_regfile.sv
`timescale 1ns/1ps

module mips_regfile
    import mips_isa_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rs_idx,
    input  reg_idx_t rt_idx,
    input  logic     wr_en,
    input  reg_idx_t wr_idx,
    input  word_t    wr_data,
    output word_t    rs_data,
    output word_t    rt_data,
    output word_t    v0
);

    localparam reg_idx_t v0_idx = 5'd2;

    word_t regs [32];

    // one write per clock, r0 never changes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_idx != '0)) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // reads are combinational
    assign rs_data = regs[rs_idx];
    assign rt_data = regs[rt_idx];

    // result register for the monitor port
    assign v0 = regs[v0_idx];

endmodule

// File: hdl/mips_data_ram.sv
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mips_data_ram
    import mips_isa_pkg::*;
    import mips_bus_pkg::*;
(
    input  logic      clk,
    input  data_req_t data_req,
    input  load_req_t load,
    input  logic      idle,
    output word_t     readdata
);

    localparam int idx_w = $clog2(`MIPS_RAM_WORDS);

    word_t mem [`MIPS_RAM_WORDS];

    logic [idx_w-1:0] core_idx;
    logic [idx_w-1:0] load_idx;
    logic             load_we;

    // word index, byte lanes ignored
    assign core_idx = data_req.addr[idx_w+1:2];
    assign load_idx = load.addr[idx_w+1:2];

    // load port only while the core is stopped
    assign load_we = idle && load.valid;

    // read is combinational, ready in the mem cycle
    assign readdata = mem[core_idx];

    always_ff @(posedge clk) begin
        if (load_we) begin
            mem[load_idx] <= load.data;
        end else if (data_req.write) begin
            mem[core_idx] <= data_req.writedata;
        end
    end

endmodule

// File: hdl/mips_cpu.sv
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mips_cpu
    import mips_isa_pkg::*;
    import mips_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    input  word_t     instr_readdata,
    input  word_t     data_readdata,
    input  word_t     rs_data,
    input  word_t     rt_data,
    output word_t     instr_address,
    output data_req_t data_req,
    output reg_idx_t  rs_idx,
    output reg_idx_t  rt_idx,
    output reg_idx_t  wr_idx,
    output logic      wr_en,
    output word_t     wr_data,
    output logic      active,
    output logic      idle
);

    cpu_state_e state;

    // pc points at the instruction in flight
    word_t pc;
    word_t ir;
    word_t branch_target;
    logic  delay_pending;

    opcode_e  opcode;
    funct_e   funct;
    reg_idx_t rd_idx;
    word_t    imm_ext;
    word_t    pc_plus4;
    word_t    taken_target;
    word_t    alu_result;
    logic     is_lw;
    logic     is_sw;
    logic     is_mem;
    logic     is_alu_r;
    logic     is_addiu;
    logic     is_jr;
    logic     is_taken;

    // decode of the latched instruction
    assign opcode  = opcode_e'(ir[31:26]);
    assign funct   = funct_e'(ir[5:0]);
    assign rs_idx  = field_rs(ir);
    assign rt_idx  = field_rt(ir);
    assign rd_idx  = field_rd(ir);
    assign imm_ext = sign_extend(ir[15:0]);

    assign is_lw    = (opcode == op_lw);
    assign is_sw    = (opcode == op_sw);
    assign is_mem   = is_lw || is_sw;
    assign is_addiu = (opcode == op_addiu);
    assign is_jr    = (opcode == op_special) && (funct == fn_jr);
    assign is_alu_r = (opcode == op_special) && ((funct == fn_addu) || (funct == fn_subu));

    assign pc_plus4     = pc + 32'd4;
    // branch offset counts words from the delay slot
    assign taken_target = is_jr ? rs_data : pc_plus4 + (imm_ext << 2);

    always_comb begin
        case (opcode)
            op_beq:     is_taken = (rs_data == rt_data);
            op_bne:     is_taken = (rs_data != rt_data);
            op_special: is_taken = is_jr;
            // bltz/bgez not in the subset, run as nop
            op_regimm:  is_taken = 1'b0;
            default:    is_taken = 1'b0;
        endcase
    end

    always_comb begin
        if (is_addiu) begin
            alu_result = rs_data + imm_ext;
        end else if (funct == fn_subu) begin
            alu_result = rs_data - rt_data;
        end else begin
            alu_result = rs_data + rt_data;
        end
    end

    // register write, ALU in exec, load data in mem
    always_comb begin
        wr_en   = 1'b0;
        wr_idx  = rd_idx;
        wr_data = alu_result;
        if (state == st_exec) begin
            if (is_alu_r) begin
                wr_en = 1'b1;
            end else if (is_addiu) begin
                wr_en  = 1'b1;
                wr_idx = rt_idx;
            end
        end else if ((state == st_mem) && is_lw) begin
            wr_en   = 1'b1;
            wr_idx  = rt_idx;
            wr_data = data_readdata;
        end
    end

    // bus active for the single mem cycle
    always_comb begin
        data_req = data_req_none;
        if (state == st_mem) begin
            data_req.addr      = rs_data + imm_ext;
            data_req.writedata = rt_data;
            data_req.write     = is_sw;
            data_req.read      = is_lw;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_fetch) begin
            ir <= instr_readdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= st_idle;
            pc            <= `MIPS_RESET_VECTOR;
            branch_target <= '0;
            delay_pending <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_fetch;
                    end
                end
                st_fetch: begin
                    state <= st_exec;
                end
                st_exec, st_mem: begin
                    if ((state == st_exec) && is_mem) begin
                        state <= st_mem;
                    end else if (delay_pending) begin
                        // delay slot retired, take the saved target
                        pc            <= branch_target;
                        delay_pending <= 1'b0;
                        state         <= (branch_target == `MIPS_HALT_ADDR) ? st_halt_slot
                                                                             : st_fetch;
                    end else begin
                        pc    <= pc_plus4;
                        state <= st_fetch;
                        if (is_taken) begin
                            branch_target <= taken_target;
                            delay_pending <= 1'b1;
                        end
                    end
                end
                st_halt_slot: begin
                    // rearm for the next start
                    pc    <= `MIPS_RESET_VECTOR;
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    assign instr_address = pc;
    assign active        = (state != st_idle);
    assign idle          = (state == st_idle);

endmodule

// File: hdl/mips_subsys_top.sv
`timescale 1ns/1ps

module mips_subsys_top
    import mips_isa_pkg::*;
    import mips_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    input  load_req_t load,
    output logic      active,
    output data_req_t data_mon,
    output word_t     register_v0
);

    word_t    instr_address;
    word_t    instr_readdata;
    word_t    data_readdata;
    word_t    rs_data;
    word_t    rt_data;
    word_t    wr_data;
    reg_idx_t rs_idx;
    reg_idx_t rt_idx;
    reg_idx_t wr_idx;
    logic     wr_en;
    logic     idle;

    // core data bus goes straight out as the monitor
    mips_cpu cpu_i (
        .clk,
        .rst_n,
        .start,
        .instr_readdata,
        .data_readdata,
        .rs_data,
        .rt_data,
        .instr_address,
        .data_req (data_mon),
        .rs_idx,
        .rt_idx,
        .wr_idx,
        .wr_en,
        .wr_data,
        .active,
        .idle
    );

    mips_instr_rom rom_i (
        .instr_address,
        .instr_readdata
    );

    mips_regfile regfile_i (
        .clk,
        .rst_n,
        .rs_idx,
        .rt_idx,
        .wr_en,
        .wr_idx,
        .wr_data,
        .rs_data,
        .rt_data,
        .v0 (register_v0)
    );

    mips_data_ram ram_i (
        .clk,
        .data_req (data_mon),
        .load,
        .idle,
        .readdata (data_readdata)
    );

endmodule

// File: tb/mips_subsys_asserts.sv
`timescale 1ns/1ps

module mips_subsys_asserts
    import mips_bus_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input logic      active,
    input data_req_t data_mon
);

    // failed assertions so far
    int fail_count = 0;

    // core stays stopped after reset release until a start
    a_idle_after_reset: assert property (@(posedge clk) $rose(rst_n) |=> !active)
        else begin
            $error("active high in the cycle after reset release");
            fail_count++;
        end

    a_no_rw_clash: assert property (@(posedge clk) disable iff (!rst_n)
        !(data_mon.write && data_mon.read))
        else begin
            $error("data bus read and write in the same cycle");
            fail_count++;
        end

    // word accesses only
    a_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        (data_mon.write || data_mon.read) |-> (data_mon.addr[1:0] == 2'b00))
        else begin
            $error("unaligned data address on the bus");
            fail_count++;
        end

    a_write_when_active: assert property (@(posedge clk) disable iff (!rst_n)
        data_mon.write |-> active)
        else begin
            $error("data write while the core is idle");
            fail_count++;
        end

endmodule

bind mips_subsys_top mips_subsys_asserts asserts_i (
    .clk,
    .rst_n,
    .active,
    .data_mon
);

// File: tb/mips_subsys_tb.sv
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mips_subsys_tb
    import mips_isa_pkg::*;
    import mips_bus_pkg::*;
();

    logic      clk;
    logic      rst_n;
    logic      start;
    load_req_t load;
    logic      active;
    data_req_t data_mon;
    word_t     register_v0;

    logic [15:0] lfsr_state;
    int          errors;
    int          checks;
    int          tests;
    int          err_mark;
    int          store_count;
    int          fall_count;
    data_req_t   last_store;
    logic        active_q;

    mips_subsys_top dut_i (
        .clk,
        .rst_n,
        .start,
        .load,
        .active,
        .data_mon,
        .register_v0
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // bus and active monitor on the falling edge
    always @(negedge clk) begin
        if (data_mon.write) begin
            store_count++;
            last_store = data_mon;
        end
        if (active_q && !active) begin
            fall_count++;
        end
        active_q = active;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output word_t value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            value      = {value[30:0], lfsr_state[15]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_req(input string name, input data_req_t got, input data_req_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic wait_active(input logic level, input int limit);
        int cycles;
        bit ok;
        ok     = 1'b0;
        cycles = 0;
        while (!ok && (cycles < limit)) begin
            @(posedge clk);
            cycles++;
            if (active === level) begin
                ok = 1'b1;
            end
        end
        if (!ok) begin
            errors++;
            $display("timeout at %0t: active did not reach %b within %0d cycles",
                     $time, level, limit);
        end
    endtask

    // A at word 0, B at word 4
    task automatic load_operands(input word_t a, input word_t b);
        @(posedge clk);
        load <= '{addr: 32'h0, data: a, valid: 1'b1};
        @(posedge clk);
        load <= '{addr: 32'h4, data: b, valid: 1'b1};
        @(posedge clk);
        load <= '0;
    endtask

    task automatic pulse_start();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic run_program(input word_t a, input word_t b, input bit extra_start);
        word_t     exp_v0;
        data_req_t exp_store;
        // expected store is A+B and v0 is A-B+1, or 0 on equal operands
        exp_v0    = (a == b) ? 32'd0 : a - b + 32'd1;
        exp_store = '{addr: `MIPS_RESULT_ADDR, writedata: a + b, write: 1'b1, read: 1'b0};
        load_operands(a, b);
        store_count = 0;
        fall_count  = 0;
        last_store  = '0;
        pulse_start();
        wait_active(1'b1, 4);
        if (extra_start) begin
            repeat (3) @(posedge clk);
            pulse_start();
        end
        wait_active(1'b0, 100);
        if (extra_start) begin
            // a late start must not relaunch the program
            repeat (4) @(posedge clk);
            check_bit("active", active, 1'b0);
        end
        check_count("store count", store_count, 1);
        check_req("data_mon", last_store, exp_store);
        check_word("register_v0", register_v0, exp_v0);
        check_count("active falls", fall_count, 1);
    endtask

    task automatic begin_test();
        tests++;
        err_mark = errors;
    endtask

    task automatic end_test(input string name);
        $display("test %0d %s: %s", tests, name, (errors == err_mark) ? "ok" : "errors");
    endtask

    // hard stop in case a run never finishes
    initial begin
        repeat (8000) @(posedge clk);
        $display("simulation ran out of cycles before the tests finished");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        word_t a;
        word_t b;
        word_t ctl;
        rst_n       = 1'b0;
        start       = 1'b0;
        load        = '0;
        lfsr_state  = 16'd37833;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        store_count = 0;
        fall_count  = 0;
        last_store  = '0;
        active_q    = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        begin_test();
        repeat (4) @(posedge clk);
        check_bit("active", active, 1'b0);
        check_req("data_mon", data_mon, '0);
        check_word("register_v0", register_v0, '0);
        check_count("store count", store_count, 0);
        end_test("reset state");

        begin_test();
        take_bits(32, a);
        take_bits(32, b);
        while (b == a) begin
            take_bits(32, b);
        end
        run_program(a, b, 1'b0);
        end_test("unequal operands");

        begin_test();
        take_bits(32, a);
        run_program(a, a, 1'b0);
        end_test("equal operands, branch taken");

        begin_test();
        take_bits(32, a);
        take_bits(32, b);
        run_program(a, b, 1'b1);
        end_test("start while active");

        begin_test();
        for (int i = 0; i < 20; i++) begin
            take_bits(32, a);
            take_bits(32, b);
            take_bits(1, ctl);
            if (ctl[0]) begin
                b = a;
            end
            run_program(a, b, 1'b0);
        end
        end_test("back-to-back runs");

        errors = errors + dut_i.asserts_i.fail_count;
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: mips_subsys.f
+incdir+hdl
hdl/mips_isa_pkg.sv
hdl/mips_bus_pkg.sv
hdl/mips_instr_rom.sv
hdl/mips_regfile.sv
hdl/mips_data_ram.sv
hdl/mips_cpu.sv
hdl/mips_subsys_top.sv
tb/mips_subsys_asserts.sv
tb/mips_subsys_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = mips_subsys_tb
FILELIST = mips_subsys.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "*** PASSED ***" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
